// File: tb.f
source/rv_core_pkg.sv
source/decode_bus_if.sv
source/core_control.sv
source/pc_unit.sv
source/inst_decoder.sv
source/reg_file.sv
source/execute_unit.sv
source/rv_core_top.sv
tests/core_assertions.sv
tests/core_tb.sv

// File: tests/core_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rv32i core testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module core_tb;

    localparam logic [31:0] RESET_PC       = 32'h8000_0000;
    localparam int          TIMEOUT_CYCLES = 3000;

    logic        clk        = 1'b0;
    logic        reset      = 1'b1;
    logic [31:0] imem_rdata = '0;
    logic        imem_ready = 1'b0;
    logic [31:0] dmem_rdata = '0;
    logic        dmem_ready = 1'b0;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic        dmem_req;
    logic        dmem_we;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        retire;

    logic [31:0] imem [64];
    logic [31:0] dmem [256];
    logic [31:0] exp_addr_q [$];
    logic [31:0] exp_data_q [$];
    logic [31:0] cur_pc = RESET_PC;
    logic [31:0] loop_addr;
    logic [31:0] lcg_state = 32'h49bd_309e;
    logic        imem_busy = 1'b0;
    logic        dmem_busy = 1'b0;
    logic [1:0]  imem_count = '0;
    logic [1:0]  dmem_count = '0;
    logic        loop_reached = 1'b0;
    int          path_count = 0;
    int          retire_count = 0;
    int          retire_at_loop = 0;
    int          errors = 0;
    int          cycles;

    always #5 clk = ~clk;

    rv_core_top #(
        .RESET_PC (RESET_PC)
    ) UUT (
        .clk        (clk),
        .reset      (reset),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .imem_ready (imem_ready),
        .dmem_req   (dmem_req),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .dmem_ready (dmem_ready),
        .retire     (retire)
    );

    bind rv_core_top core_assertions #(.RESET_PC(RESET_PC)) checks (
        .clk        (clk),
        .reset      (reset),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_ready (imem_ready),
        .dmem_req   (dmem_req),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_ready (dmem_ready),
        .retire     (retire)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // rv32i instruction formats
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_core_pkg::OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_core_pkg::OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11],
                rv_core_pkg::OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_core_pkg::OP_JAL};
    endfunction

    task automatic emit(input logic [31:0] word, input bit on_path);
        imem[cur_pc[7:2]] = word;
        cur_pc = cur_pc + 32'd4;
        if (on_path) path_count++;  // instructions that really retire
    endtask

    task automatic emit_store(input logic [4:0] rs2, input logic [11:0] offset,
                              input logic [31:0] data, input bit on_path);
        emit(enc_s(offset, rs2, 5'd0), on_path);
        if (on_path) begin
            exp_addr_q.push_back({{20{offset[11]}}, offset});
            exp_data_q.push_back(data);
        end
    endtask

    task automatic fill_memories();
        for (int i = 0; i < 64; i++) begin
            imem[i] = ~(RESET_PC + 32'(i * 4));
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'hdead_0000 | 32'(i * 4);
        end
    endtask

    task automatic build_program();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sum;
        logic [31:0] diff;
        logic [31:0] sll_val;
        logic [31:0] upper;
        logic [31:0] mark;
        logic [31:0] flag1;
        bit          beq_t;
        bit          bne_t;
        bit          blt_t;
        bit          bltu_t;
        bit          bge_t;
        bit          bgeu_t;
        a       = 32'd12;
        b       = 32'hffff_fff9;  // -7
        sum     = a + b;
        diff    = b - a;
        sll_val = a << a[4:0];
        upper   = {20'h12345, 12'h000} ^ 32'h0000_0678;
        beq_t   = (a == a);
        bne_t   = (a != a);
        blt_t   = ($signed(b) < $signed(a));
        bltu_t  = (b < a);
        bge_t   = ($signed(a) >= $signed(b));
        bgeu_t  = (a >= b);
        flag1   = 32'd0;
        if (!bne_t) flag1 = 32'd1;
        if (!blt_t) flag1 = 32'd99;

        emit(enc_i(12'd12, 5'd0, 3'b000, 5'd1, rv_core_pkg::OP_IMM), 1'b1);
        emit(enc_i(b[11:0], 5'd0, 3'b000, 5'd2, rv_core_pkg::OP_IMM), 1'b1);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1'b1);      // add
        emit_store(5'd3, 12'h100, sum, 1'b1);
        emit(enc_r(7'h20, 5'd1, 5'd2, 3'b000, 5'd4), 1'b1);      // sub
        emit_store(5'd4, 12'h104, diff, 1'b1);
        emit(enc_r(7'h20, 5'd1, 5'd2, 3'b101, 5'd5), 1'b1);      // sra
        emit_store(5'd5, 12'h108, $signed(b) >>> a[4:0], 1'b1);
        emit(enc_r(7'h00, 5'd1, 5'd2, 3'b101, 5'd6), 1'b1);      // srl
        emit_store(5'd6, 12'h10c, b >> a[4:0], 1'b1);
        emit(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd7), 1'b1);      // slt
        emit_store(5'd7, 12'h110, {31'b0, $signed(b) < $signed(a)}, 1'b1);
        emit(enc_r(7'h00, 5'd1, 5'd2, 3'b011, 5'd8), 1'b1);      // sltu
        emit_store(5'd8, 12'h114, {31'b0, b < a}, 1'b1);
        emit({20'h12345, 5'd9, rv_core_pkg::OP_LUI}, 1'b1);
        emit(enc_i(12'h678, 5'd9, 3'b100, 5'd9, rv_core_pkg::OP_IMM), 1'b1);
        emit_store(5'd9, 12'h118, upper, 1'b1);
        mark = cur_pc;
        emit({20'h00001, 5'd10, rv_core_pkg::OP_AUIPC}, 1'b1);
        emit_store(5'd10, 12'h11c, mark + 32'h0000_1000, 1'b1);
        emit(enc_r(7'h00, 5'd1, 5'd1, 3'b001, 5'd11), 1'b1);     // sll
        emit_store(5'd11, 12'h120, sll_val, 1'b1);
        emit(enc_r(7'h00, 5'd3, 5'd11, 3'b110, 5'd12), 1'b1);    // or
        emit_store(5'd12, 12'h124, sll_val | sum, 1'b1);
        emit(enc_r(7'h00, 5'd4, 5'd9, 3'b111, 5'd13), 1'b1);     // and
        emit_store(5'd13, 12'h128, upper & diff, 1'b1);
        emit(enc_i(12'd5, 5'd0, 3'b000, 5'd0, rv_core_pkg::OP_IMM), 1'b1);  // x0 write
        emit_store(5'd0, 12'h12c, 32'd0, 1'b1);
        emit(enc_i(12'h100, 5'd0, 3'b010, 5'd14, rv_core_pkg::OP_LOAD), 1'b1);
        emit(enc_r(7'h00, 5'd1, 5'd14, 3'b000, 5'd15), 1'b1);
        emit_store(5'd15, 12'h130, sum + a, 1'b1);

        // each branch skips one instruction when taken
        emit(enc_b(13'd8, 5'd1, 5'd1, 3'b000), 1'b1);
        emit_store(5'd1, 12'h1f0, a, !beq_t);
        emit(enc_b(13'd8, 5'd1, 5'd1, 3'b001), 1'b1);
        emit(enc_i(12'd1, 5'd0, 3'b000, 5'd16, rv_core_pkg::OP_IMM), !bne_t);
        emit(enc_b(13'd8, 5'd1, 5'd2, 3'b100), 1'b1);
        emit(enc_i(12'd99, 5'd0, 3'b000, 5'd16, rv_core_pkg::OP_IMM), !blt_t);
        emit(enc_b(13'd8, 5'd1, 5'd2, 3'b110), 1'b1);
        emit(enc_i(12'd2, 5'd0, 3'b000, 5'd17, rv_core_pkg::OP_IMM), !bltu_t);
        emit(enc_b(13'd8, 5'd2, 5'd1, 3'b101), 1'b1);
        emit_store(5'd1, 12'h1f4, a, !bge_t);
        emit(enc_b(13'd8, 5'd2, 5'd1, 3'b111), 1'b1);
        emit(enc_i(12'd3, 5'd0, 3'b000, 5'd18, rv_core_pkg::OP_IMM), !bgeu_t);
        emit_store(5'd16, 12'h134, flag1, 1'b1);
        emit_store(5'd17, 12'h138, bltu_t ? 32'd0 : 32'd2, 1'b1);
        emit_store(5'd18, 12'h13c, bgeu_t ? 32'd0 : 32'd3, 1'b1);

        mark = cur_pc;
        emit(enc_j(21'd8, 5'd19), 1'b1);
        emit_store(5'd1, 12'h1f8, a, 1'b0);
        emit_store(5'd19, 12'h140, mark + 32'd4, 1'b1);
        mark = cur_pc;
        emit({20'h00000, 5'd20, rv_core_pkg::OP_AUIPC}, 1'b1);
        emit(enc_i(12'd12, 5'd20, 3'b000, 5'd21, rv_core_pkg::OP_JALR), 1'b1);
        emit_store(5'd1, 12'h1fc, a, 1'b0);
        emit_store(5'd21, 12'h144, mark + 32'd8, 1'b1);
        loop_addr = cur_pc;
        emit(enc_j(21'd0, 5'd0), 1'b0);  // jal to self
    endtask

    // both memories in one block so the delay draws come in a fixed order
    always @(posedge clk) begin : memory_models
        logic [31:0] rnd;
        logic        dmem_fire;
        if (reset) begin
            imem_ready <= 1'b0;
            dmem_ready <= 1'b0;
            imem_busy  <= 1'b0;
            dmem_busy  <= 1'b0;
        end else begin
            if (imem_ready) begin
                imem_ready <= 1'b0;
            end else if (imem_req && !imem_busy) begin
                rnd = lcg_next();
                imem_busy  <= (rnd[17:16] != 2'd0);
                imem_count <= rnd[17:16] - 2'd1;
                if (rnd[17:16] == 2'd0) begin
                    imem_ready <= 1'b1;
                    imem_rdata <= imem[imem_addr[7:2]];
                end
            end else if (imem_busy) begin
                imem_count <= imem_count - 2'd1;
                if (imem_count == 2'd0) begin
                    imem_busy  <= 1'b0;
                    imem_ready <= 1'b1;
                    imem_rdata <= imem[imem_addr[7:2]];
                end
            end
            dmem_fire = 1'b0;
            if (dmem_ready) begin
                dmem_ready <= 1'b0;
            end else if (dmem_req && !dmem_busy) begin
                rnd = lcg_next();
                dmem_busy  <= (rnd[17:16] != 2'd0);
                dmem_count <= rnd[17:16] - 2'd1;
                dmem_fire  = (rnd[17:16] == 2'd0);
            end else if (dmem_busy) begin
                dmem_count <= dmem_count - 2'd1;
                if (dmem_count == 2'd0) begin
                    dmem_busy <= 1'b0;
                    dmem_fire = 1'b1;
                end
            end
            if (dmem_fire) begin
                dmem_ready <= 1'b1;
                if (dmem_addr[31:10] != '0) begin
                    errors++;
                    $display("data access outside memory at %h", dmem_addr);
                end
                if (dmem_we) dmem[dmem_addr[9:2]] <= dmem_wdata;
                else dmem_rdata <= dmem[dmem_addr[9:2]];
            end
        end
    end

    always @(posedge clk) begin : store_check
        if (!reset && dmem_req && dmem_we && dmem_ready) begin
            if (exp_addr_q.size() == 0) begin
                errors++;
                $display("store to %h that the program should never make", dmem_addr);
            end else begin
                if (dmem_addr !== exp_addr_q[0]) begin
                    errors++;
                    $display("Mismatch dmem_addr: expected %h, got %h",
                             exp_addr_q[0], dmem_addr);
                end
                if (dmem_wdata !== exp_data_q[0]) begin
                    errors++;
                    $display("Mismatch dmem_wdata at %h: expected %h, got %h",
                             exp_addr_q[0], exp_data_q[0], dmem_wdata);
                end
                void'(exp_addr_q.pop_front());
                void'(exp_data_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin : retire_count_check
        if (!reset && retire) retire_count <= retire_count + 1;
        // count is final when the loop is fetched the first time
        if (!reset && imem_req && imem_ready && (imem_addr == loop_addr) && !loop_reached) begin
            loop_reached   <= 1'b1;
            retire_at_loop <= retire_count;
        end
    end

    initial begin
        fill_memories();
        build_program();
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        cycles = 0;
        while (!loop_reached && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (!loop_reached) begin
            errors++;
            $display("timeout: the program never reached its final loop");
        end else begin
            repeat (20) @(posedge clk);  // let the loop spin a little
            if (exp_addr_q.size() != 0) begin
                errors++;
                $display("%0d expected stores never happened", exp_addr_q.size());
            end
            if (retire_at_loop != path_count) begin
                errors++;
                $display("Mismatch retire_count: expected %h, got %h",
                         path_count, retire_at_loop);
            end
        end
        $display("errors: %0d testbench, %0d assertion", errors, UUT.checks.fail_count);
        if (errors == 0 && UUT.checks.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/core_assertions.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core handshake and reset checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module core_assertions #(
    parameter rv_core_pkg::word_t RESET_PC = 32'h8000_0000
) (
    input logic               clk,
    input logic               reset,
    input logic               imem_req,
    input rv_core_pkg::word_t imem_addr,
    input logic               imem_ready,
    input logic               dmem_req,
    input logic               dmem_we,
    input rv_core_pkg::word_t dmem_addr,
    input rv_core_pkg::word_t dmem_wdata,
    input logic               dmem_ready,
    input logic               retire
);

    int   fail_count = 0;
    logic reset_seen = 1'b0;  // outputs are defined after the first reset edge

    always @(posedge clk) begin
        reset_seen <= reset;
    end

    a_reset_quiet: assert property (@(posedge clk)
        (reset_seen && reset) |-> (!imem_req && !dmem_req && !retire))
        else begin
            fail_count++;
            $error("request or retire active during reset");
        end

    a_first_addr: assert property (@(posedge clk)
        $fell(reset) |-> (imem_addr == RESET_PC))
        else begin
            fail_count++;
            $error("pc does not start at the reset address");
        end

    a_first_fetch: assert property (@(posedge clk)
        $fell(reset) |=> (imem_req && (imem_addr == RESET_PC)))
        else begin
            fail_count++;
            $error("first fetch missing or at wrong address");
        end

    // request and qualifiers held until ready
    a_imem_hold: assert property (@(posedge clk) disable iff (reset)
        (imem_req && !imem_ready) |=> (imem_req && $stable(imem_addr)))
        else begin
            fail_count++;
            $error("fetch request dropped or address moved");
        end

    a_dmem_hold: assert property (@(posedge clk) disable iff (reset)
        (dmem_req && !dmem_ready) |=>
        (dmem_req && $stable(dmem_addr) && $stable(dmem_we) && $stable(dmem_wdata)))
        else begin
            fail_count++;
            $error("data request dropped or qualifiers moved");
        end

    a_imem_drop: assert property (@(posedge clk) disable iff (reset)
        (imem_req && imem_ready) |=> !imem_req)
        else begin
            fail_count++;
            $error("fetch request still high after ready");
        end

    a_dmem_drop: assert property (@(posedge clk) disable iff (reset)
        (dmem_req && dmem_ready) |=> !dmem_req)
        else begin
            fail_count++;
            $error("data request still high after ready");
        end

    a_retire_pulse: assert property (@(posedge clk) disable iff (reset)
        retire |=> !retire)
        else begin
            fail_count++;
            $error("retire held for more than one cycle");
        end

endmodule

`default_nettype wire

// File: source/rv_core_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// multicycle rv32i core top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
    parameter rv_core_pkg::word_t RESET_PC = 32'h8000_0000
) (
    input  logic               clk,
    input  logic               reset,
    // instruction memory
    output logic               imem_req,
    output rv_core_pkg::word_t imem_addr,
    input  rv_core_pkg::word_t imem_rdata,
    input  logic               imem_ready,
    // data memory
    output logic               dmem_req,
    output logic               dmem_we,
    output rv_core_pkg::word_t dmem_addr,
    output rv_core_pkg::word_t dmem_wdata,
    input  rv_core_pkg::word_t dmem_rdata,
    input  logic               dmem_ready,
    output logic               retire
);

    decode_bus_if dec ();

    rv_core_pkg::word_t      pc;
    rv_core_pkg::word_t      snpc;
    rv_core_pkg::inst_word_u ir;
    rv_core_pkg::word_t      rs1_data;
    rv_core_pkg::word_t      rs2_data;
    rv_core_pkg::word_t      alu_result;
    rv_core_pkg::word_t      next_pc;
    rv_core_pkg::word_t      wb_data;
    logic                    ir_load;
    logic                    pc_load;
    logic                    reg_we;

    core_control u_control (
        .clk        (clk),
        .reset      (reset),
        .dec        (dec.sink),
        .imem_ready (imem_ready),
        .dmem_ready (dmem_ready),
        .imem_req   (imem_req),
        .dmem_req   (dmem_req),
        .dmem_we    (dmem_we),
        .ir_load    (ir_load),
        .pc_load    (pc_load),
        .reg_we     (reg_we),
        .retire     (retire)
    );

    pc_unit #(
        .RESET_PC (RESET_PC)
    ) u_pc (
        .clk        (clk),
        .reset      (reset),
        .pc_load    (pc_load),
        .ir_load    (ir_load),
        .next_pc    (next_pc),
        .imem_rdata (imem_rdata),
        .pc         (pc),
        .snpc       (snpc),
        .ir         (ir)
    );

    inst_decoder u_decoder (
        .ir  (ir),
        .dec (dec.source)
    );

    reg_file u_regs (
        .clk      (clk),
        .reset    (reset),
        .dec      (dec.sink),
        .reg_we   (reg_we),
        .wb_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    execute_unit u_execute (
        .dec        (dec.sink),
        .pc         (pc),
        .snpc       (snpc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .dmem_rdata (dmem_rdata),
        .alu_result (alu_result),
        .next_pc    (next_pc),
        .wb_data    (wb_data)
    );

    assign imem_addr  = pc;
    assign dmem_addr  = alu_result;  // effective address
    assign dmem_wdata = rs2_data;

endmodule

`default_nettype wire

// File: source/execute_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// alu, branch compare and writeback select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    decode_bus_if.sink         dec,
    input  rv_core_pkg::word_t pc,
    input  rv_core_pkg::word_t snpc,
    input  rv_core_pkg::word_t rs1_data,
    input  rv_core_pkg::word_t rs2_data,
    input  rv_core_pkg::word_t dmem_rdata,
    output rv_core_pkg::word_t alu_result,
    output rv_core_pkg::word_t next_pc,
    output rv_core_pkg::word_t wb_data
);

    rv_core_pkg::word_t alu_a;
    rv_core_pkg::word_t alu_b;
    rv_core_pkg::word_t target;   // pc relative jump target
    logic [4:0]         shamt;
    logic               taken;

    always_comb begin
        if (dec.inst_class == rv_core_pkg::CLASS_UPPER) begin
            alu_a = dec.funct3[0] ? '0 : pc;  // lui : auipc
        end else begin
            alu_a = rs1_data;
        end
    end

    assign alu_b = dec.use_imm ? dec.imm : rs2_data;
    assign shamt = alu_b[4:0];

    always_comb begin
        case (dec.alu_op)
            rv_core_pkg::ALU_SUB:  alu_result = alu_a - alu_b;
            rv_core_pkg::ALU_SLL:  alu_result = alu_a << shamt;
            rv_core_pkg::ALU_SLT:  alu_result = {31'b0, $signed(alu_a) < $signed(alu_b)};
            rv_core_pkg::ALU_SLTU: alu_result = {31'b0, alu_a < alu_b};
            rv_core_pkg::ALU_XOR:  alu_result = alu_a ^ alu_b;
            rv_core_pkg::ALU_SRL:  alu_result = alu_a >> shamt;
            rv_core_pkg::ALU_SRA:  alu_result = $unsigned($signed(alu_a) >>> shamt);
            rv_core_pkg::ALU_OR:   alu_result = alu_a | alu_b;
            rv_core_pkg::ALU_AND:  alu_result = alu_a & alu_b;
            default:               alu_result = alu_a + alu_b;
        endcase
    end

    // branch compare always on the two registers
    always_comb begin
        case (dec.funct3)
            3'b000:  taken = (rs1_data == rs2_data);
            3'b001:  taken = (rs1_data != rs2_data);
            3'b100:  taken = ($signed(rs1_data) <  $signed(rs2_data));
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  taken = (rs1_data <  rs2_data);
            3'b111:  taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    assign target = pc + dec.imm;

    always_comb begin
        case (dec.inst_class)
            rv_core_pkg::CLASS_JAL:    next_pc = target;
            rv_core_pkg::CLASS_BRANCH: next_pc = taken ? target : snpc;
            rv_core_pkg::CLASS_JALR:   next_pc = {alu_result[31:1], 1'b0};
            default:                   next_pc = snpc;
        endcase
    end

    always_comb begin
        case (dec.inst_class)
            rv_core_pkg::CLASS_JAL,
            rv_core_pkg::CLASS_JALR: wb_data = snpc;        // link address
            rv_core_pkg::CLASS_LOAD: wb_data = dmem_rdata;  // valid in ready cycle
            default:                 wb_data = alu_result;
        endcase
    end

endmodule

`default_nettype wire

// File: source/reg_file.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// integer register file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic               clk,
    input  logic               reset,
    decode_bus_if.sink         dec,
    input  logic               reg_we,
    input  rv_core_pkg::word_t wb_data,
    output rv_core_pkg::word_t rs1_data,
    output rv_core_pkg::word_t rs2_data
);

    rv_core_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_we && (dec.rd != '0)) begin  // x0 stays zero
            regs[dec.rd] <= wb_data;
        end
    end

    assign rs1_data = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
    assign rs2_data = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

endmodule

`default_nettype wire

// File: source/inst_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rv32i instruction decoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  rv_core_pkg::inst_word_u ir,
    decode_bus_if.source            dec
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic       sign;

    assign opcode = ir.r_i.opcode;
    assign funct7 = ir.r_i.funct7;
    assign sign   = funct7[6];  // inst[31]

    assign dec.rs1 = ir.r_i.rs1;
    assign dec.rs2 = ir.r_i.rs2;
    assign dec.rd  = ir.r_i.rd;

    always_comb begin
        case (opcode)
            rv_core_pkg::OP_REG,
            rv_core_pkg::OP_IMM:    dec.inst_class = rv_core_pkg::CLASS_ALU;
            rv_core_pkg::OP_LOAD:   dec.inst_class = rv_core_pkg::CLASS_LOAD;
            rv_core_pkg::OP_STORE:  dec.inst_class = rv_core_pkg::CLASS_STORE;
            rv_core_pkg::OP_BRANCH: dec.inst_class = rv_core_pkg::CLASS_BRANCH;
            rv_core_pkg::OP_JAL:    dec.inst_class = rv_core_pkg::CLASS_JAL;
            rv_core_pkg::OP_JALR:   dec.inst_class = rv_core_pkg::CLASS_JALR;
            rv_core_pkg::OP_LUI,
            rv_core_pkg::OP_AUIPC:  dec.inst_class = rv_core_pkg::CLASS_UPPER;
            default:                dec.inst_class = rv_core_pkg::CLASS_ILLEGAL;
        endcase
    end

    // U type has no funct3, bit 0 tells lui from auipc
    always_comb begin
        if (dec.inst_class == rv_core_pkg::CLASS_UPPER) begin
            dec.funct3 = {2'b00, (opcode == rv_core_pkg::OP_LUI)};
        end else begin
            dec.funct3 = ir.r_i.funct3;
        end
    end

    assign dec.use_imm = (opcode != rv_core_pkg::OP_REG) && (opcode != rv_core_pkg::OP_BRANCH);

    always_comb begin
        case (dec.inst_class)
            rv_core_pkg::CLASS_STORE:
                dec.imm = {{20{sign}}, ir.s_b.imm_hi, ir.s_b.imm_lo};
            rv_core_pkg::CLASS_BRANCH:
                dec.imm = {{19{sign}}, sign, ir.s_b.imm_lo[0], ir.s_b.imm_hi[5:0],
                           ir.s_b.imm_lo[4:1], 1'b0};
            rv_core_pkg::CLASS_UPPER:
                dec.imm = {funct7, ir.r_i.rs2, ir.r_i.rs1, ir.r_i.funct3, 12'h000};
            rv_core_pkg::CLASS_JAL:
                dec.imm = {{11{sign}}, sign, ir.r_i.rs1, ir.r_i.funct3, ir.r_i.rs2[0],
                           funct7[5:0], ir.r_i.rs2[4:1], 1'b0};
            default:  // I type: alu imm, load, jalr
                dec.imm = {{20{sign}}, funct7, ir.r_i.rs2};
        endcase
    end

    always_comb begin
        dec.alu_op = rv_core_pkg::ALU_ADD;  // address and link math
        if (dec.inst_class == rv_core_pkg::CLASS_ALU) begin
            case (ir.r_i.funct3)
                3'b000: begin
                    if (opcode == rv_core_pkg::OP_REG && funct7[5]) begin
                        dec.alu_op = rv_core_pkg::ALU_SUB;
                    end
                end
                3'b001:  dec.alu_op = rv_core_pkg::ALU_SLL;
                3'b010:  dec.alu_op = rv_core_pkg::ALU_SLT;
                3'b011:  dec.alu_op = rv_core_pkg::ALU_SLTU;
                3'b100:  dec.alu_op = rv_core_pkg::ALU_XOR;
                3'b101:  dec.alu_op = funct7[5] ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
                3'b110:  dec.alu_op = rv_core_pkg::ALU_OR;
                default: dec.alu_op = rv_core_pkg::ALU_AND;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/pc_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// program counter and instruction register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pc_unit #(
    parameter rv_core_pkg::word_t RESET_PC = 32'h8000_0000
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    pc_load,
    input  logic                    ir_load,
    input  rv_core_pkg::word_t      next_pc,
    input  rv_core_pkg::word_t      imem_rdata,
    output rv_core_pkg::word_t      pc,
    output rv_core_pkg::word_t      snpc,
    output rv_core_pkg::inst_word_u ir
);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (pc_load) begin
            pc <= next_pc;
        end
    end

    // fetched word is only valid in the ready cycle
    always_ff @(posedge clk) begin
        if (ir_load) begin
            ir <= imem_rdata;
        end
    end

    assign snpc = pc + 32'd4;

endmodule

`default_nettype wire

// File: source/core_control.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch / execute / memory phase control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module core_control (
    input  logic         clk,
    input  logic         reset,
    decode_bus_if.sink   dec,
    input  logic         imem_ready,
    input  logic         dmem_ready,
    output logic         imem_req,
    output logic         dmem_req,
    output logic         dmem_we,
    output logic         ir_load,
    output logic         pc_load,
    output logic         reg_we,
    output logic         retire
);

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM
    } state_t;

    state_t state;
    state_t state_next;
    logic   is_mem;     // load or store
    logic   exec_wr;    // writes rd at end of exec

    assign is_mem  = (dec.inst_class == rv_core_pkg::CLASS_LOAD) ||
                     (dec.inst_class == rv_core_pkg::CLASS_STORE);
    assign exec_wr = (dec.inst_class == rv_core_pkg::CLASS_ALU)  ||
                     (dec.inst_class == rv_core_pkg::CLASS_UPPER) ||
                     (dec.inst_class == rv_core_pkg::CLASS_JAL)  ||
                     (dec.inst_class == rv_core_pkg::CLASS_JALR);

    always_comb begin
        state_next = state;
        case (state)
            FETCH:   if (imem_ready) state_next = EXEC;
            EXEC:    state_next = is_mem ? MEM : FETCH;
            MEM:     if (dmem_ready) state_next = FETCH;
            default: state_next = FETCH;
        endcase
    end

    // requests follow the next phase, so they drop right after ready
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= FETCH;
            imem_req <= 1'b0;
            dmem_req <= 1'b0;
            dmem_we  <= 1'b0;
        end else begin
            state    <= state_next;
            imem_req <= (state_next == FETCH);
            dmem_req <= (state_next == MEM);
            dmem_we  <= (state_next == MEM) &&
                        (dec.inst_class == rv_core_pkg::CLASS_STORE);
        end
    end

    assign ir_load = (state == FETCH) && imem_ready;

    // illegal ops land here too and retire without a write
    assign retire  = ((state == EXEC) && !is_mem) || ((state == MEM) && dmem_ready);
    assign pc_load = retire;
    assign reg_we  = ((state == EXEC) && exec_wr) ||
                     ((state == MEM) && dmem_ready &&
                      (dec.inst_class == rv_core_pkg::CLASS_LOAD));

endmodule

`default_nettype wire

// File: source/decode_bus_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decoded instruction fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface decode_bus_if;

    rv_core_pkg::inst_class_t inst_class;
    rv_core_pkg::alu_op_t     alu_op;
    logic [2:0]               funct3;  // for upper class bit 0 marks lui
    rv_core_pkg::reg_addr_t   rs1;
    rv_core_pkg::reg_addr_t   rs2;
    rv_core_pkg::reg_addr_t   rd;
    rv_core_pkg::word_t       imm;
    logic                     use_imm;  // imm as second alu operand

    modport source (output inst_class, alu_op, funct3, rs1, rs2, rd, imm, use_imm);
    modport sink   (input  inst_class, alu_op, funct3, rs1, rs2, rd, imm, use_imm);

endinterface

`default_nettype wire

// File: source/rv_core_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rv32i core shared types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // base opcodes, bits [6:0]
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef enum logic [2:0] {
        CLASS_ALU,
        CLASS_LOAD,
        CLASS_STORE,
        CLASS_BRANCH,
        CLASS_JAL,
        CLASS_JALR,
        CLASS_UPPER,  // lui and auipc
        CLASS_ILLEGAL
    } inst_class_t;

    typedef struct packed {
        logic [6:0] funct7;  // also imm[11:5] for I type
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } inst_r_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } inst_s_b_t;

    typedef union packed {
        inst_r_i_t r_i;
        inst_s_b_t s_b;
    } inst_word_u;

endpackage

`default_nettype wire
